// ==== bus_pkg.sv ====
/*
 serial bus protocol definitions
 field widths, slave select codes and the host and serial link structs
*/
package bus_pkg;

	localparam int addr_len = 12;
	localparam int data_len = 8;
	localparam int sel_len = 2;

	// bit counter spans the longest serial phase
	localparam int cnt_len = $clog2(addr_len);
	localparam logic [cnt_len-1:0] addr_last = cnt_len'(addr_len - 1);
	localparam logic [cnt_len-1:0] data_last = cnt_len'(data_len - 1);

	// slave select codes, 3 reaches no slave
	localparam logic [sel_len-1:0] sel_4k = 2'd0;
	localparam logic [sel_len-1:0] sel_2k_a = 2'd1;
	localparam logic [sel_len-1:0] sel_2k_b = 2'd2;

	typedef struct packed {
		logic write;
		logic [sel_len-1:0] sel;
		logic [addr_len-1:0] addr;
		logic [data_len-1:0] data; // write data
	} host_req_t;

	typedef struct packed {
		logic [data_len-1:0] data; // read data
	} host_rsp_t;

	typedef struct packed {
		logic master_valid;
		logic write_en;
		logic sbit;
	} ser_fwd_t;

	typedef struct packed {
		logic slave_ready;
		logic slave_valid;
		logic sbit;
	} ser_bwd_t;

endpackage

// ==== mem_pkg.sv ====
/*
 memory slave sizes
 word depths of the block RAM slaves and the address width they need
*/
package mem_pkg;

	localparam int depth_4k = 4096;
	localparam int depth_2k = 2048;

	// index bits for a RAM of the given depth
	function automatic int addr_bits(input int depth);
		return $clog2(depth);
	endfunction

endpackage

// ==== bus_arbiter.sv ====
/*
 bus arbiter for two masters
 alternates priority on conflicts and keeps a grant until its request falls
*/
`timescale 1ns/1ps

module bus_arbiter (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [1:0] bus_req,
	input  logic [1:0] done,
	output logic [1:0] grant
);

	typedef enum logic [1:0] {A_IDLE, A_M0, A_M1} arb_state_t;

	arb_state_t state;
	arb_state_t pick;
	arb_state_t next;
	logic last; // index of the master granted last

	always_comb begin
		if (bus_req == 2'b11)
			pick = last ? A_M0 : A_M1; // the other master goes first
		else if (bus_req[0])
			pick = A_M0;
		else if (bus_req[1])
			pick = A_M1;
		else
			pick = A_IDLE;
	end

	always_comb begin
		next = state;
		case (state)
			A_IDLE: next = pick;
			A_M0: if (done[0]) next = pick; // hand over right away
			A_M1: if (done[1]) next = pick;
			default: next = A_IDLE;
		endcase
	end

	// last starts at 1 so m1 (index 0) takes the first conflict
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= A_IDLE;
			last <= 1'b1;
		end else begin
			state <= next;
			if (next == A_M0)
				last <= 1'b0;
			else if (next == A_M1)
				last <= 1'b1;
		end
	end

	assign grant = {state == A_M1, state == A_M0};

endmodule

// ==== bus_master_port.sv ====
/*
 bus master port
 takes a parallel host request over req/ack, sends it bit-serially to a
 slave once granted and returns the read data to the host
*/
`timescale 1ns/1ps

module bus_master_port (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        req,
	output logic                        ack,
	input  bus_pkg::host_req_t          req_data,
	output bus_pkg::host_rsp_t          rsp,
	output logic                        bus_req,
	input  logic                        grant,
	output logic [bus_pkg::sel_len-1:0] sel,
	output bus_pkg::ser_fwd_t           fwd,
	input  bus_pkg::ser_bwd_t           bwd
);

	typedef enum logic [2:0] {M_IDLE, M_REQ, M_ADDR, M_DATA, M_READ, M_ACK} m_state_t;

	m_state_t state;
	logic [bus_pkg::cnt_len-1:0] cnt;
	logic write_q;
	logic [bus_pkg::addr_len-1:0] addr_sr;
	logic [bus_pkg::data_len-1:0] data_sr;
	logic [bus_pkg::data_len-1:0] rd_sr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= M_IDLE;
			cnt <= '0;
			write_q <= 1'b0;
			sel <= '0;
		end else begin
			case (state)
				M_IDLE: if (req) begin
					write_q <= req_data.write;
					sel <= req_data.sel;
					state <= M_REQ;
				end
				M_REQ: if (grant && bwd.slave_ready) begin // slave free and bus ours
					cnt <= '0;
					state <= M_ADDR;
				end
				M_ADDR: begin
					cnt <= cnt + 1'b1;
					if (cnt == bus_pkg::addr_last) begin
						cnt <= '0;
						state <= write_q ? M_DATA : M_READ;
					end
				end
				M_DATA: begin
					cnt <= cnt + 1'b1;
					if (cnt == bus_pkg::data_last)
						state <= M_ACK;
				end
				M_READ: if (bwd.slave_valid) begin // slave may take a while to start
					cnt <= cnt + 1'b1;
					if (cnt == bus_pkg::data_last)
						state <= M_ACK;
				end
				M_ACK: if (!req) state <= M_IDLE; // wait for host to drop req
				default: state <= M_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			M_IDLE: if (req) begin
				addr_sr <= req_data.addr;
				data_sr <= req_data.data;
			end
			M_ADDR: addr_sr <= addr_sr >> 1; // lsb first
			M_DATA: data_sr <= data_sr >> 1;
			M_READ: if (bwd.slave_valid) rd_sr <= {bwd.sbit, rd_sr[bus_pkg::data_len-1:1]};
			default: ;
		endcase
	end

	assign ack = (state == M_ACK);
	// low in ack so the arbiter sees the transfer end
	assign bus_req = (state == M_REQ) || (state == M_ADDR) ||
			(state == M_DATA) || (state == M_READ);

	always_comb begin
		fwd.master_valid = (state == M_ADDR) || (state == M_DATA);
		fwd.write_en = write_q && fwd.master_valid;
		if (state == M_ADDR)
			fwd.sbit = addr_sr[0];
		else if (state == M_DATA)
			fwd.sbit = data_sr[0];
		else
			fwd.sbit = 1'b0;
		rsp.data = rd_sr; // held until next read
	end

endmodule

// ==== bus_interconnect.sv ====
/*
 bus interconnect
 arbitrates the two masters and routes the granted master's serial
 lines to the slave it selects
*/
`timescale 1ns/1ps

module bus_interconnect (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [1:0]                       m_bus_req,
	input  logic [1:0][bus_pkg::sel_len-1:0] m_sel,
	input  bus_pkg::ser_fwd_t [1:0]          m_fwd,
	output logic [1:0]                       m_grant,
	output bus_pkg::ser_bwd_t [1:0]          m_bwd,
	output bus_pkg::ser_fwd_t [2:0]          s_fwd,
	input  bus_pkg::ser_bwd_t [2:0]          s_bwd
);

	logic [1:0] done;
	logic owner;
	logic [bus_pkg::sel_len-1:0] tgt;

	assign done = m_grant & ~m_bus_req; // granted master let go
	assign owner = m_grant[1];
	assign tgt = m_sel[owner];

	bus_arbiter u_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.bus_req(m_bus_req),
		.done(done),
		.grant(m_grant)
	);

	// idle paths stay all zero
	always_comb begin
		s_fwd = '0;
		m_bwd = '0;
		if (|m_grant) begin
			case (tgt)
				bus_pkg::sel_4k: begin
					s_fwd[0] = m_fwd[owner];
					m_bwd[owner] = s_bwd[0];
				end
				bus_pkg::sel_2k_a: begin
					s_fwd[1] = m_fwd[owner];
					m_bwd[owner] = s_bwd[1];
				end
				bus_pkg::sel_2k_b: begin
					s_fwd[2] = m_fwd[owner];
					m_bwd[owner] = s_bwd[2];
				end
				default: ; // no slave behind this code
			endcase
		end
	end

endmodule

// ==== bram_slave.sv ====
/*
 block RAM slave
 shifts in an address and write data, accesses a RAM of mem_depth words
 and shifts read data back to the master
*/
`timescale 1ns/1ps

module bram_slave #(
	parameter int mem_depth = mem_pkg::depth_4k
) (
	input  logic              clk,
	input  logic              rst_n,
	input  bus_pkg::ser_fwd_t fwd,
	output bus_pkg::ser_bwd_t bwd
);

	typedef enum logic [2:0] {S_IDLE, S_ADDR, S_DATA, S_WRITE, S_READ, S_SEND} s_state_t;

	s_state_t state;
	logic [bus_pkg::cnt_len-1:0] cnt;
	logic write_q;
	logic [bus_pkg::addr_len-1:0] addr_sr;
	logic [bus_pkg::data_len-1:0] data_sr;
	logic [bus_pkg::data_len-1:0] rd_sr;
	logic [mem_pkg::addr_bits(mem_depth)-1:0] ram_addr;
	logic [bus_pkg::data_len-1:0] ram [mem_depth];

	assign ram_addr = addr_sr[mem_pkg::addr_bits(mem_depth)-1:0]; // upper bits dropped

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			cnt <= '0;
			write_q <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (fwd.master_valid) begin // first address bit
					write_q <= fwd.write_en;
					cnt <= bus_pkg::cnt_len'(1);
					state <= S_ADDR;
				end
				S_ADDR: if (fwd.master_valid) begin
					cnt <= cnt + 1'b1;
					if (cnt == bus_pkg::addr_last) begin
						cnt <= '0;
						state <= write_q ? S_DATA : S_READ;
					end
				end
				S_DATA: if (fwd.master_valid) begin
					cnt <= cnt + 1'b1;
					if (cnt == bus_pkg::data_last)
						state <= S_WRITE;
				end
				S_WRITE: state <= S_IDLE;
				S_READ: begin
					cnt <= '0;
					state <= S_SEND;
				end
				S_SEND: begin
					cnt <= cnt + 1'b1;
					if (cnt == bus_pkg::data_last)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			S_IDLE, S_ADDR: if (fwd.master_valid)
				addr_sr <= {fwd.sbit, addr_sr[bus_pkg::addr_len-1:1]}; // lsb first
			S_DATA: if (fwd.master_valid)
				data_sr <= {fwd.sbit, data_sr[bus_pkg::data_len-1:1]};
			S_WRITE: ram[ram_addr] <= data_sr;
			S_READ: rd_sr <= ram[ram_addr]; // registered read
			S_SEND: rd_sr <= rd_sr >> 1;
			default: ;
		endcase
	end

	always_comb begin
		bwd.slave_ready = (state == S_IDLE); // busy through the whole access
		bwd.slave_valid = (state == S_SEND);
		bwd.sbit = (state == S_SEND) && rd_sr[0];
	end

endmodule

// ==== serial_bus_top.sv ====
/*
 serial bus top level
 two master ports, the interconnect and three block RAM slaves
*/
`timescale 1ns/1ps

module serial_bus_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [1:0]               req,
	output wire  [1:0]               ack,
	input  bus_pkg::host_req_t [1:0] req_data,
	output wire bus_pkg::host_rsp_t [1:0] rsp
);

	wire [1:0] bus_req;
	wire [1:0] grant;
	wire [1:0][bus_pkg::sel_len-1:0] sel;
	wire bus_pkg::ser_fwd_t [1:0] m_fwd;
	wire bus_pkg::ser_bwd_t [1:0] m_bwd;
	wire bus_pkg::ser_fwd_t [2:0] s_fwd; // 0: 4k, 1: 2k a, 2: 2k b
	wire bus_pkg::ser_bwd_t [2:0] s_bwd;

	bus_master_port u_master_0 (
		.clk(clk), .rst_n(rst_n), .req(req[0]), .ack(ack[0]),
		.req_data(req_data[0]), .rsp(rsp[0]), .bus_req(bus_req[0]),
		.grant(grant[0]), .sel(sel[0]), .fwd(m_fwd[0]), .bwd(m_bwd[0])
	);

	bus_master_port u_master_1 (
		.clk(clk), .rst_n(rst_n), .req(req[1]), .ack(ack[1]),
		.req_data(req_data[1]), .rsp(rsp[1]), .bus_req(bus_req[1]),
		.grant(grant[1]), .sel(sel[1]), .fwd(m_fwd[1]), .bwd(m_bwd[1])
	);

	bus_interconnect u_interconnect (
		.clk(clk), .rst_n(rst_n), .m_bus_req(bus_req), .m_sel(sel),
		.m_fwd(m_fwd), .m_grant(grant), .m_bwd(m_bwd),
		.s_fwd(s_fwd), .s_bwd(s_bwd)
	);

	bram_slave #(.mem_depth(mem_pkg::depth_4k)) u_slave_4k (
		.clk(clk), .rst_n(rst_n), .fwd(s_fwd[0]), .bwd(s_bwd[0])
	);

	bram_slave #(.mem_depth(mem_pkg::depth_2k)) u_slave_2k_a (
		.clk(clk), .rst_n(rst_n), .fwd(s_fwd[1]), .bwd(s_bwd[1])
	);

	bram_slave #(.mem_depth(mem_pkg::depth_2k)) u_slave_2k_b (
		.clk(clk), .rst_n(rst_n), .fwd(s_fwd[2]), .bwd(s_bwd[2])
	);

endmodule

// ==== tb_serial_bus.sv ====
/*
 serial bus testbench
 runs both hosts from the stim file and checks read data and the req/ack handshake
*/
`timescale 1ns/1ps

module tb_serial_bus;

	localparam int clk_period = 100;
	localparam int reset_cycles = 5;
	localparam int max_lines = 32;
	localparam int cycles_per_line = 100;
	localparam logic [31:0] rng_seed = 32'h03c5a584;

	logic clk;
	logic rst_n;
	wire [1:0] req;
	wire [1:0] ack;
	wire bus_pkg::host_req_t [1:0] req_data;
	wire bus_pkg::host_rsp_t [1:0] rsp;

	bus_pkg::host_req_t stim_req [2][max_lines];
	bus_pkg::host_rsp_t stim_exp [2][max_lines];
	int stim_dep [2][max_lines]; // acks of the other master needed first
	int n_lines [2];
	int total_lines;
	bit stim_ready;

	int req_cnt [2];
	int ack_cnt [2];
	logic [1:0] req_prev;
	logic [1:0] ack_prev;

	serial_bus_top u_serial_bus_top (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.ack(ack),
		.req_data(req_data),
		.rsp(rsp)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_rsp(input bus_pkg::host_rsp_t got, input bus_pkg::host_rsp_t exp,
			input int m, input int idx);
		if (got !== exp)
			stop_on_error($sformatf("FAILED at %0t ns: master %0d request %0d read %h, expected %h",
				$time, m, idx, got.data, exp.data));
	endtask

	task automatic check_ack_count(input int m, input int got, input int exp);
		if (got != exp)
			stop_on_error($sformatf("FAILED at %0t ns: master %0d gave %0d acks for %0d requests",
				$time, m, got, exp));
	endtask

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// req/ack monitor on pre-edge values
	// an ack edge seen here happened at the previous clock edge, when req was req_prev
	always @(posedge clk) begin
		if (!rst_n) begin
			req_cnt = '{0, 0};
			ack_cnt = '{0, 0};
			req_prev = 2'b00;
			ack_prev = 2'b00;
		end else begin
			for (int k = 0; k < 2; k++) begin
				if (req[k] && !req_prev[k])
					req_cnt[k]++;
				if (ack[k] && !ack_prev[k]) begin
					ack_cnt[k]++;
					if (!req_prev[k] || ack_cnt[k] != req_cnt[k])
						stop_on_error($sformatf("master %0d raised ack with no open request", k));
				end
				if (!ack[k] && ack_prev[k] && req_prev[k])
					stop_on_error($sformatf("master %0d dropped ack while req was still high", k));
			end
			req_prev = req;
			ack_prev = ack;
		end
	end

	for (genvar m = 0; m < 2; m++) begin : host
		localparam int other = 1 - m;
		logic req_h;
		bus_pkg::host_req_t data_h;
		bit finished;
		logic [31:0] rng;
		int gap;
		int hold;

		assign req[m] = req_h;
		assign req_data[m] = data_h;

		initial begin
			req_h = 1'b0;
			data_h = '0;
			finished = 1'b0;
			rng = (m == 0) ? rng_seed : xorshift(rng_seed); // own sequence per host
			wait (stim_ready);
			for (int i = 0; i < n_lines[m]; i++) begin
				while (ack_cnt[other] < stim_dep[m][i])
					@(negedge clk);
				rng = xorshift(rng);
				gap = int'(rng[2:0]); // idle 0 to 7 cycles
				hold = int'(rng[5:3]); // req kept high after ack
				repeat (gap) @(negedge clk);
				@(negedge clk);
				data_h = stim_req[m][i];
				req_h = 1'b1;
				do @(negedge clk); while (!ack[m]);
				if (!stim_req[m][i].write)
					check_rsp(rsp[m], stim_exp[m][i], m, i);
				repeat (hold) @(negedge clk);
				req_h = 1'b0;
				do @(negedge clk); while (ack[m]);
			end
			finished = 1'b1;
		end
	end

	// the bus must finish within a fixed budget per transaction
	initial begin
		int limit;
		wait (stim_ready);
		limit = total_lines * cycles_per_line;
		repeat (limit) @(posedge clk);
		stop_on_error($sformatf("bus hung: transfers not done after %0d cycles", limit));
	end

	initial begin
		int fd;
		int code;
		int n;
		int m;
		int wr;
		int dep;
		string line;
		logic [bus_pkg::sel_len-1:0] sel_v;
		logic [bus_pkg::addr_len-1:0] addr_v;
		logic [bus_pkg::data_len-1:0] data_v;
		bus_pkg::host_req_t rq;
		rst_n = 1'b0;
		stim_ready = 1'b0;
		n_lines = '{0, 0};
		fd = $fopen("serial_bus_stim.txt", "r");
		if (fd == 0)
			stop_on_error("cannot open the stimulus file serial_bus_stim.txt");
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code != 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%d %d %h %h %h %d", m, wr, sel_v, addr_v, data_v, dep);
				if (n == 6) begin
					if (m < 0 || m > 1 || n_lines[m] >= max_lines)
						stop_on_error($sformatf("bad master number or too many lines: %s", line));
					rq.write = wr[0];
					rq.sel = sel_v;
					rq.addr = addr_v;
					rq.data = wr[0] ? data_v : '0; // reads carry the expected byte instead
					stim_req[m][n_lines[m]] = rq;
					stim_exp[m][n_lines[m]].data = data_v;
					stim_dep[m][n_lines[m]] = dep;
					n_lines[m]++;
				end else if (n > 0) begin
					stop_on_error($sformatf("malformed stimulus line: %s", line));
				end
			end
		end
		$fclose(fd);
		total_lines = n_lines[0] + n_lines[1];
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		stim_ready = 1'b1;
		wait (host[0].finished && host[1].finished);
		repeat (2) @(posedge clk);
		check_ack_count(0, ack_cnt[0], n_lines[0]);
		check_ack_count(1, ack_cnt[1], n_lines[1]);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== serial_bus_stim.txt ====
# master write sel addr data after; sel, addr, data in hex, the rest decimal
# data is the expected byte on reads; after = acks of the other master to wait for
0 1 0 123 a5 0
1 1 2 fa0 c3 0
0 0 0 123 a5 0
1 0 2 7a0 c3 0
0 1 0 fff 3c 0
1 1 1 300 9e 0
0 0 0 fff 3c 0
1 0 1 300 9e 0
0 1 1 805 77 0
0 0 1 005 77 0
0 1 0 040 11 0
0 1 1 040 22 0
0 1 2 040 33 0
0 0 0 040 11 0
0 0 1 040 22 0
0 0 2 040 33 0
0 1 0 555 e1 4
1 0 0 555 e1 13
1 1 0 555 b2 13
0 0 0 555 b2 6

// ==== all.f ====
bus_pkg.sv
mem_pkg.sv
bus_arbiter.sv
bus_master_port.sv
bus_interconnect.sv
bram_slave.sv
serial_bus_top.sv
tb_serial_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the serial bus testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f all.f \
	--top-module tb_serial_bus -o tb_serial_bus \
	&& { ./obj_dir/tb_serial_bus > sim.log 2>&1 || true; }
cat sim.log 2>/dev/null
grep -q "ALL CHECKS PASSED" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
